//--- sources.f
+incdir+bench
common/exec_pkg.sv
src/operand_forward.sv
alu/alu.sv
src/branch_unit.sv
src/mem_request.sv
src/result_regs.sv
src/exec_stage.sv
bench/exec_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sources.f --top-module exec_stage_tb; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vexec_stage_tb)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1

//--- bench/exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// Source operand after the forwarding rule
function automatic word_t resolve_operand(reg_addr_t src, word_t data, reg_addr_t prev_rd,
                                          word_t prev_val, opcode_t prev_op);
    logic writes;   // Previous instruction wrote a register
    writes = prev_op inside {op_op, op_imm, op_lui, op_auipc, op_jal, op_jalr};
    if (writes && prev_rd != 5'd0 && src == prev_rd)
        return prev_val;
    return data;
endfunction

// Write-back value
function automatic word_t alu_value(opcode_t op, funct3_t f3, funct7_t f7, word_t a, word_t b,
                                    word_t pc_v, word_t ii, word_t iu);
    word_t                  y;
    logic [shamt_width-1:0] sh;
    logic                   base_ok;   // funct7 accepted for single-meaning codes
    y       = (op == op_imm) ? ii : b;
    sh      = y[shamt_width-1:0];
    base_ok = (op == op_imm) || (f7 == funct7_base);
    if (op == op_lui)
        return iu;
    if (op == op_auipc)
        return pc_v + iu;
    if (op == op_jal || op == op_jalr)
        return pc_v + pc_step;
    if (op != op_op && op != op_imm)
        return '0;
    case (f3)
        f3_add_sub:
        begin
            if (base_ok)
                return a + y;
            if (f7 == funct7_alt)
                return a - y;
        end
        f3_sll:
        begin
            if (f7 == funct7_base)
                return a << sh;
        end
        f3_slt:
        begin
            if (base_ok)
                return {31'b0, $signed(a) < $signed(y)};
        end
        f3_sltu:
        begin
            if (base_ok)
                return {31'b0, a < y};
        end
        f3_xor:
        begin
            if (base_ok)
                return a ^ y;
        end
        f3_or:
        begin
            if (base_ok)
                return a | y;
        end
        f3_and:
        begin
            if (base_ok)
                return a & y;
        end
        f3_srl_sra:
        begin
            if (f7 == funct7_base)
                return a >> sh;
            if (f7 == funct7_alt)
                return $signed(a) >>> sh;   // Sign fill
        end
        default:
        begin
        end
    endcase
    return '0;
endfunction

// Taken flag in the top bit, target below
function automatic logic [32:0] branch_outcome(opcode_t op, funct3_t f3, word_t a, word_t b,
                                               word_t pc_v, word_t ib, word_t ii, word_t ij);
    logic hit;
    case (f3)
        f3_beq:  hit = (a == b);
        f3_bne:  hit = (a != b);
        f3_blt:  hit = ($signed(a) < $signed(b));
        f3_bge:  hit = ($signed(a) >= $signed(b));
        f3_bltu: hit = (a < b);
        f3_bgeu: hit = (a >= b);
        default: hit = 1'b0;
    endcase
    if (op == op_branch && hit)
        return {1'b1, pc_v + ib};
    if (op == op_jal)
        return {1'b1, pc_v + ij};
    if (op == op_jalr && f3 == f3_jalr)
        return {1'b1, (a + ii) & ~32'd1};
    return '0;
endfunction

// Address in the upper word, store data in the lower word
function automatic logic [63:0] mem_access(opcode_t op, funct3_t f3, word_t a, word_t b,
                                           word_t ii, word_t is);
    if (op == op_load && f3 inside {f3_lb, f3_lh, f3_lw, f3_lbu, f3_lhu})
        return {a + ii, 32'h0};
    if (op == op_store)
    begin
        case (f3)
            f3_sb:   return {a + is, 24'h0, b[7:0]};
            f3_sh:   return {a + is, 16'h0, b[15:0]};
            f3_sw:   return {a + is, b};
            default: return '0;
        endcase
    end
    return '0;
endfunction

`endif

//--- bench/exec_stage_tb.sv
`default_nettype none

module exec_stage_tb
    import exec_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic      clk;
    logic      rst_n;
    logic      halt;
    word_t     pc;
    opcode_t   opcode;
    funct3_t   funct3;
    funct7_t   funct7;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr_in;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm_i;
    word_t     imm_s;
    word_t     imm_b;
    word_t     imm_u;
    word_t     imm_j;
    word_t     rd_data;
    reg_addr_t rd_addr;
    logic      branch_en;
    word_t     branch_addr;
    word_t     mem_addr;
    word_t     mem_data;
    opcode_t   opcode_out;
    funct3_t   funct3_out;

    // Expected register contents, i.e. the shadow of the outputs
    word_t     e_rd_data;
    reg_addr_t e_rd_addr;
    logic      e_branch_en;
    word_t     e_branch_addr;
    word_t     e_mem_addr;
    word_t     e_mem_data;
    opcode_t   e_opcode;
    funct3_t   e_funct3;
    logic      model_armed;   // Set once the reference has seen a reset edge

    int          check_errors;
    int          timeout_errors;
    logic [31:0] seed;
    logic [31:0] r;
    int          i;
    int          f;

    `include "exec_model.svh"

    exec_stage dut_i (.*);

    always #5 clk = ~clk;

    //////////////////////////////////////////////////
    // Reference model and checking
    //////////////////////////////////////////////////
    function logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
        assert (act === exp)
        else
        begin
            $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
            check_errors++;
        end
    endtask

    task automatic compare_outputs();
        check_value("rd_data", rd_data, e_rd_data);
        check_value("rd_addr", 32'(rd_addr), 32'(e_rd_addr));
        check_value("branch_en", 32'(branch_en), 32'(e_branch_en));
        check_value("branch_addr", branch_addr, e_branch_addr);
        check_value("mem_addr", mem_addr, e_mem_addr);
        check_value("mem_data", mem_data, e_mem_data);
        check_value("opcode_out", 32'(opcode_out), 32'(e_opcode));
        check_value("funct3_out", 32'(funct3_out), 32'(e_funct3));
    endtask

    task automatic clear_reference();
        e_rd_data     = '0;
        e_rd_addr     = '0;
        e_branch_en   = 1'b0;
        e_branch_addr = '0;
        e_mem_addr    = '0;
        e_mem_data    = '0;
        e_opcode      = '0;
        e_funct3      = '0;
    endtask

    task automatic update_reference();
        word_t       a;
        word_t       b;
        logic [32:0] br;
        logic [63:0] mem;
        a   = resolve_operand(rs1_addr, rs1_data, e_rd_addr, e_rd_data, e_opcode);
        b   = resolve_operand(rs2_addr, rs2_data, e_rd_addr, e_rd_data, e_opcode);
        br  = branch_outcome(opcode, funct3, a, b, pc, imm_b, imm_i, imm_j);
        mem = mem_access(opcode, funct3, a, b, imm_i, imm_s);
        e_rd_data     = alu_value(opcode, funct3, funct7, a, b, pc, imm_i, imm_u);
        e_rd_addr     = rd_addr_in;
        e_branch_en   = br[32];
        e_branch_addr = br[31:0];
        e_mem_addr    = mem[63:32];
        e_mem_data    = mem[31:0];
        e_opcode      = opcode;
        e_funct3      = funct3;
    endtask

    // Outputs read here still hold the values from the previous edge
    always @(posedge clk)
    begin
        if (model_armed)
            compare_outputs();
        if (!rst_n)
        begin
            clear_reference();
            model_armed = 1'b1;
        end
        else if (halt)
            e_branch_en = 1'b0;   // Everything else frozen
        else
            update_reference();
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////
    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic randomize_inputs();
        logic [31:0] addr_bits;
        pc         = next_random() & 32'hffff_fffc;
        rs1_data   = next_random();
        rs2_data   = next_random();
        imm_i      = next_random();
        imm_s      = next_random();
        imm_b      = next_random();
        imm_u      = next_random();
        imm_j      = next_random();
        addr_bits  = next_random();
        rs1_addr   = {1'b1, addr_bits[3:0]};   // Sources x16..x31
        rs2_addr   = {1'b1, addr_bits[7:4]};
        rd_addr_in = {1'b0, addr_bits[11:8]};  // Destinations x0..x15
        funct7     = funct7_base;
    endtask

    task automatic issue(input opcode_t op, input funct3_t f3, input reg_addr_t s1,
                         input reg_addr_t s2, input reg_addr_t d);
        step_cycle();
        randomize_inputs();
        opcode     = op;
        funct3     = f3;
        rs1_addr   = s1;
        rs2_addr   = s2;
        rd_addr_in = d;
    endtask

    task automatic wait_reset_seen();
        int count;
        count = 0;
        while (!model_armed && count < 10)
        begin
            step_cycle();
            count++;
        end
        if (!model_armed)
        begin
            $display("Timeout: no clock edge arrived during reset");
            timeout_errors++;
        end
    endtask

    task automatic wait_branch_low();
        int count;
        count = 0;
        while (branch_en !== 1'b0 && count < 5)
        begin
            step_cycle();
            randomize_inputs();
            count++;
        end
        if (branch_en !== 1'b0)
        begin
            $display("Timeout: branch_en stayed high while halted");
            timeout_errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial
    begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        halt           = 1'b0;
        pc             = '0;
        opcode         = '0;
        funct3         = '0;
        funct7         = '0;
        rs1_addr       = '0;
        rs2_addr       = '0;
        rd_addr_in     = '0;
        rs1_data       = '0;
        rs2_data       = '0;
        imm_i          = '0;
        imm_s          = '0;
        imm_b          = '0;
        imm_u          = '0;
        imm_j          = '0;
        model_armed    = 1'b0;
        check_errors   = 0;
        timeout_errors = 0;
        seed           = 32'h1eb00176;

        wait_reset_seen();
        step_cycle();          // Second reset cycle
        rst_n = 1'b1;

        // Arithmetic, including odd funct7 values
        for (i = 0; i < 60; i++)
        begin
            step_cycle();
            randomize_inputs();
            r = next_random();
            case (r[2:0])
                3'd0, 3'd1, 3'd2: opcode = op_op;
                3'd3, 3'd4, 3'd5: opcode = op_imm;
                3'd6:             opcode = op_lui;
                default:          opcode = op_auipc;
            endcase
            funct3 = r[5:3];
            case (r[7:6])
                2'd2:    funct7 = funct7_alt;
                2'd3:    funct7 = r[14:8];
                default: funct7 = funct7_base;
            endcase
        end

        // Every branch code, equal operands now and then
        for (f = 0; f < 8; f++)
        begin
            for (i = 0; i < 4; i++)
            begin
                issue(op_branch, funct3_t'(f), 5'd20, 5'd21, 5'd3);
                r = next_random();
                if (r[0])
                    rs2_data = rs1_data;
            end
        end
        for (i = 0; i < 8; i++)
            issue((i < 3) ? op_jal : op_jalr, (i < 6) ? f3_jalr : funct3_t'(i - 5),
                  5'd22, 5'd23, 5'd4);

        // Loads then stores, all eight codes each
        for (f = 0; f < 16; f++)
            issue((f < 8) ? op_load : op_store, funct3_t'(f % 8), 5'd24, 5'd25, 5'd2);

        // Back-to-back dependencies
        issue(op_op, f3_add_sub, 5'd16, 5'd17, 5'd5);
        issue(op_imm, f3_xor, 5'd5, 5'd18, 5'd6);
        issue(op_store, f3_sw, 5'd6, 5'd6, 5'd7);
        issue(op_op, f3_or, 5'd7, 5'd7, 5'd0);      // Store wrote nothing
        issue(op_op, f3_add_sub, 5'd0, 5'd0, 5'd8); // x0 never forwarded
        issue(op_branch, f3_bne, 5'd8, 5'd19, 5'd9);
        issue(op_load, f3_lw, 5'd9, 5'd9, 5'd10);   // Branch wrote nothing
        issue(op_lui, f3_add_sub, 5'd20, 5'd21, 5'd11);
        issue(op_jalr, f3_jalr, 5'd11, 5'd22, 5'd1);

        // Halt after a taken jump
        issue(op_jal, f3_jalr, 5'd16, 5'd17, 5'd12);
        step_cycle();
        randomize_inputs();
        halt = 1'b1;
        wait_branch_low();
        for (i = 0; i < 2; i++)
        begin
            step_cycle();
            randomize_inputs();
        end
        issue(op_imm, f3_add_sub, 5'd12, 5'd12, 5'd13);   // Frozen x12 still forwarded
        halt = 1'b0;
        issue(op_op, f3_sll, 5'd13, 5'd12, 5'd14);

        step_cycle();
        opcode = '0;
        step_cycle();
        step_cycle();

        $display("Summary: %0d check errors, %0d timeout errors", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/exec_stage.sv
`default_nettype none

module exec_stage import exec_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic halt,
    input  word_t     pc,
    input  opcode_t   opcode,
    input  funct3_t   funct3,
    input  funct7_t   funct7,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  reg_addr_t rd_addr_in,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    input  word_t     imm_i,
    input  word_t     imm_s,
    input  word_t     imm_b,
    input  word_t     imm_u,
    input  word_t     imm_j,
    output word_t     rd_data,
    output reg_addr_t rd_addr,
    output logic      branch_en,
    output word_t     branch_addr,
    output word_t     mem_addr,
    output word_t     mem_data,
    output opcode_t   opcode_out,
    output funct3_t   funct3_out
);

    word_t op_a;           // Resolved rs1
    word_t op_b;           // Resolved rs2
    word_t alu_result;
    logic  br_taken;
    word_t br_target;
    word_t ls_addr;
    word_t ls_store_data;

    // Previous result comes back from the output registers
    operand_forward u_forward (
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .prev_rd_addr (rd_addr),
        .prev_rd_data (rd_data),
        .prev_opcode  (opcode_out),
        .op_a         (op_a),
        .op_b         (op_b)
    );

    alu u_alu (
        .opcode     (opcode),
        .funct3     (funct3),
        .funct7     (funct7),
        .op_a       (op_a),
        .op_b       (op_b),
        .pc         (pc),
        .imm_i      (imm_i),
        .imm_u      (imm_u),
        .alu_result (alu_result)
    );

    branch_unit u_branch (
        .opcode (opcode),
        .funct3 (funct3),
        .op_a   (op_a),
        .op_b   (op_b),
        .pc     (pc),
        .imm_b  (imm_b),
        .imm_i  (imm_i),
        .imm_j  (imm_j),
        .taken  (br_taken),
        .target (br_target)
    );

    mem_request u_mem_req (
        .opcode     (opcode),
        .funct3     (funct3),
        .op_a       (op_a),
        .op_b       (op_b),
        .imm_i      (imm_i),
        .imm_s      (imm_s),
        .addr       (ls_addr),
        .store_data (ls_store_data)
    );

    result_regs u_result (
        .clk         (clk),
        .rst_n       (rst_n),
        .halt        (halt),
        .alu_result  (alu_result),
        .taken       (br_taken),
        .target      (br_target),
        .addr        (ls_addr),
        .store_data  (ls_store_data),
        .rd_addr_in  (rd_addr_in),
        .opcode      (opcode),
        .funct3      (funct3),
        .rd_data     (rd_data),
        .rd_addr     (rd_addr),
        .branch_en   (branch_en),
        .branch_addr (branch_addr),
        .mem_addr    (mem_addr),
        .mem_data    (mem_data),
        .opcode_out  (opcode_out),
        .funct3_out  (funct3_out)
    );

endmodule

`default_nettype wire

//--- src/result_regs.sv
`default_nettype none

module result_regs import exec_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic halt,
    input  word_t     alu_result,
    input  wire logic taken,
    input  word_t     target,
    input  word_t     addr,
    input  word_t     store_data,
    input  reg_addr_t rd_addr_in,
    input  opcode_t   opcode,
    input  funct3_t   funct3,
    output word_t     rd_data,
    output reg_addr_t rd_addr,
    output logic      branch_en,
    output word_t     branch_addr,
    output word_t     mem_addr,
    output word_t     mem_data,
    output opcode_t   opcode_out,
    output funct3_t   funct3_out
);

    ////////////////////////////////////////////////
    // Stage output registers
    ////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rd_data     <= '0;
            rd_addr     <= '0;
            branch_en   <= 1'b0;
            branch_addr <= '0;
            mem_addr    <= '0;
            mem_data    <= '0;
            opcode_out  <= '0;
            funct3_out  <= '0;
        end
        else if (halt)
        begin
            // Everything else holds, incoming instruction is dropped
            branch_en <= 1'b0;
        end
        else
        begin
            rd_data     <= alu_result;
            rd_addr     <= rd_addr_in;
            branch_en   <= taken;
            branch_addr <= target;
            mem_addr    <= addr;
            mem_data    <= store_data;
            opcode_out  <= opcode;   // Passed on to memory stage
            funct3_out  <= funct3;
        end
    end

endmodule

`default_nettype wire

//--- src/mem_request.sv
`default_nettype none

module mem_request import exec_pkg::*;
(
    input  opcode_t opcode,
    input  funct3_t funct3,
    input  word_t   op_a,
    input  word_t   op_b,
    input  word_t   imm_i,
    input  word_t   imm_s,
    output word_t   addr,
    output word_t   store_data
);

    always_comb
    begin
        addr       = '0;
        store_data = '0;
        if (opcode == op_load)
        begin
            case (funct3)
                f3_lb, f3_lh, f3_lw, f3_lbu, f3_lhu:
                    addr = op_a + imm_i;
                default:
                    addr = '0;   // Unknown load width
            endcase
        end
        else if (opcode == op_store)
        begin
            case (funct3)
                f3_sb:
                begin
                    addr       = op_a + imm_s;
                    store_data = word_t'(op_b[7:0]);    // Byte, zero extended
                end
                f3_sh:
                begin
                    addr       = op_a + imm_s;
                    store_data = word_t'(op_b[15:0]);   // Halfword
                end
                f3_sw:
                begin
                    addr       = op_a + imm_s;
                    store_data = op_b;
                end
                default:
                begin
                    addr       = '0;
                    store_data = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/branch_unit.sv
`default_nettype none

module branch_unit import exec_pkg::*;
(
    input  opcode_t opcode,
    input  funct3_t funct3,
    input  word_t   op_a,
    input  word_t   op_b,
    input  word_t   pc,
    input  word_t   imm_b,
    input  word_t   imm_i,
    input  word_t   imm_j,
    output logic    taken,
    output word_t   target
);

    logic cond;   // Branch condition for the current funct3

    always_comb
    begin
        case (funct3)
            f3_beq:  cond = (op_a == op_b);
            f3_bne:  cond = (op_a != op_b);
            f3_blt:  cond = ($signed(op_a) <  $signed(op_b));
            f3_bge:  cond = ($signed(op_a) >= $signed(op_b));
            f3_bltu: cond = (op_a <  op_b);
            f3_bgeu: cond = (op_a >= op_b);
            default: cond = 1'b0;
        endcase
    end

    // Target stays zero unless something is taken
    always_comb
    begin
        taken  = 1'b0;
        target = '0;
        case (opcode)
            op_branch:
            begin
                if (cond)
                begin
                    taken  = 1'b1;
                    target = pc + imm_b;
                end
            end
            op_jal:
            begin
                taken  = 1'b1;
                target = pc + imm_j;
            end
            op_jalr:
            begin
                if (funct3 == f3_jalr)
                begin
                    taken  = 1'b1;
                    target = (op_a + imm_i) & jalr_align_mask;
                end
            end
            default:
            begin
                taken  = 1'b0;
                target = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- alu/alu.sv
`default_nettype none

module alu import exec_pkg::*;
(
    input  opcode_t opcode,
    input  funct3_t funct3,
    input  funct7_t funct7,
    input  word_t   op_a,
    input  word_t   op_b,
    input  word_t   pc,
    input  word_t   imm_i,
    input  word_t   imm_u,
    output word_t   alu_result
);

    word_t                  rhs;         // op_b or imm_i
    logic [shamt_width-1:0] shamt;
    logic                   f7_base;
    logic                   f7_alt;
    logic                   plain_ok;    // funct7 check for single-meaning codes
    word_t                  int_result;

    assign rhs      = (opcode == op_imm) ? imm_i : op_b;
    assign shamt    = rhs[shamt_width-1:0];
    assign f7_base  = (funct7 == funct7_base);
    assign f7_alt   = (funct7 == funct7_alt);
    assign plain_ok = (opcode == op_imm) || f7_base;   // OP_IMM has no funct7 here

    ////////////////////////////////////////////////
    // Integer operations for OP and OP_IMM
    ////////////////////////////////////////////////
    always_comb
    begin
        int_result = '0;
        case (funct3)
            f3_add_sub:
            begin
                if (opcode == op_imm || f7_base)
                    int_result = op_a + rhs;
                else if (f7_alt)
                    int_result = op_a - rhs;   // SUB, register form only
            end
            f3_sll:
            begin
                if (f7_base)
                    int_result = op_a << shamt;
            end
            f3_slt:
            begin
                if (plain_ok)
                    int_result = word_t'($signed(op_a) < $signed(rhs));
            end
            f3_sltu:
            begin
                if (plain_ok)
                    int_result = word_t'(op_a < rhs);
            end
            f3_xor:   int_result = plain_ok ? (op_a ^ rhs) : '0;
            f3_or:    int_result = plain_ok ? (op_a | rhs) : '0;
            f3_and:   int_result = plain_ok ? (op_a & rhs) : '0;
            f3_srl_sra:
            begin
                if (f7_base)
                    int_result = op_a >> shamt;
                else if (f7_alt)
                    int_result = word_t'($signed(op_a) >>> shamt);   // Sign fill
            end
            default:  int_result = '0;
        endcase
    end

    // Result select by opcode
    always_comb
    begin
        case (opcode)
            op_op,
            op_imm:   alu_result = int_result;
            op_lui:   alu_result = imm_u;
            op_auipc: alu_result = pc + imm_u;
            op_jal,
            op_jalr:  alu_result = pc + pc_step;   // Link value
            default:  alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/operand_forward.sv
`default_nettype none

module operand_forward import exec_pkg::*;
(
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    input  reg_addr_t prev_rd_addr,
    input  word_t     prev_rd_data,
    input  opcode_t   prev_opcode,
    output word_t     op_a,
    output word_t     op_b
);

    logic prev_writes;   // Previous result is a real register write
    logic fwd_rs1;
    logic fwd_rs2;

    // Only these opcodes write rd, and x0 never holds a result
    assign prev_writes = (prev_rd_addr != '0) &&
                         (prev_opcode == op_op  || prev_opcode == op_imm   ||
                          prev_opcode == op_lui || prev_opcode == op_auipc ||
                          prev_opcode == op_jal || prev_opcode == op_jalr);

    assign fwd_rs1 = prev_writes && (rs1_addr == prev_rd_addr);
    assign fwd_rs2 = prev_writes && (rs2_addr == prev_rd_addr);

    assign op_a = fwd_rs1 ? prev_rd_data : rs1_data;
    assign op_b = fwd_rs2 ? prev_rd_data : rs2_data;

endmodule

`default_nettype wire

//--- common/exec_pkg.sv
`default_nettype none

package exec_pkg;

    ////////////////////////////////////////////////
    // Widths and basic types
    ////////////////////////////////////////////////
    localparam int xlen        = 32;
    localparam int shamt_width = 5;   // Low operand bits used as shift amount

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;   // x0 is never forwarded
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [6:0]      funct7_t;

    localparam word_t pc_step         = 32'd4;          // Link address offset
    localparam word_t jalr_align_mask = 32'hffff_fffe;  // Clears bit 0

    ////////////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////////////
    localparam opcode_t op_op     = 7'b0110011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;

    // ALU funct3, shared by OP and OP_IMM
    localparam funct3_t f3_add_sub = 3'b000;
    localparam funct3_t f3_sll     = 3'b001;
    localparam funct3_t f3_slt     = 3'b010;
    localparam funct3_t f3_sltu    = 3'b011;
    localparam funct3_t f3_xor     = 3'b100;
    localparam funct3_t f3_srl_sra = 3'b101;
    localparam funct3_t f3_or      = 3'b110;
    localparam funct3_t f3_and     = 3'b111;

    // Branch and jump funct3
    localparam funct3_t f3_beq  = 3'b000;
    localparam funct3_t f3_bne  = 3'b001;
    localparam funct3_t f3_blt  = 3'b100;
    localparam funct3_t f3_bge  = 3'b101;
    localparam funct3_t f3_bltu = 3'b110;
    localparam funct3_t f3_bgeu = 3'b111;
    localparam funct3_t f3_jalr = 3'b000;

    // Load and store funct3
    localparam funct3_t f3_lb  = 3'b000;
    localparam funct3_t f3_lh  = 3'b001;
    localparam funct3_t f3_lw  = 3'b010;
    localparam funct3_t f3_lbu = 3'b100;
    localparam funct3_t f3_lhu = 3'b101;
    localparam funct3_t f3_sb  = 3'b000;
    localparam funct3_t f3_sh  = 3'b001;
    localparam funct3_t f3_sw  = 3'b010;

    localparam funct7_t funct7_base = 7'b0000000;
    localparam funct7_t funct7_alt  = 7'b0100000;   // SUB, SRA, SRAI

endpackage

`default_nettype wire
